/* framerPkg.sv */
package framerPkg;

    localparam int windowWidth = 32;        // Sync window and data word width.
    localparam int scoreWidth = 7;          // Holds a signed score of -32 to +32.

    localparam logic [3:0] ctrlOffset = 4'h0;
    localparam logic [3:0] syncWordOffset = 4'h4;
    localparam logic [3:0] syncMaskOffset = 4'h8;
    localparam logic [3:0] statusOffset = 4'hC;

    // Writable bits of CONTROL. The spare bits are held at zero.
    localparam logic [31:0] ctrlRwMask = 32'hFFFF_7F1F;

    typedef struct packed {
        logic [15:0] wordsPerFrame;
        logic spareHi;
        logic signed [scoreWidth-1:0] syncThreshold;
        logic [2:0] spareLo;
        logic [4:0] bitsPerWord;
    } ctrlFieldsT;

    typedef union packed {
        logic [31:0] raw;
        ctrlFieldsT fields;
    } ctrlWordU;

    typedef enum logic [1:0] {
        stSearch = 2'd0,
        stCheck = 2'd1,
        stLocked = 2'd2,
        stFlywheel = 2'd3
    } syncStateT;

endpackage

/* framerCfgIf.sv */
`timescale 1ns/1ps

interface framerCfgIf;
    import framerPkg::*;

    logic [4:0] bitsPerWord;                // Word length minus one.
    logic [15:0] wordsPerFrame;             // Frame length in words, sync word included.
    logic [windowWidth-1:0] syncWord;
    logic [windowWidth-1:0] syncMask;
    logic signed [scoreWidth-1:0] syncThreshold;

    modport cfgSource (
        output bitsPerWord, wordsPerFrame, syncWord, syncMask, syncThreshold
    );

    modport cfgSink (
        input bitsPerWord, wordsPerFrame, syncWord, syncMask, syncThreshold
    );

endinterface

/* framerRegs.sv */
`timescale 1ns/1ps

module framerRegs #(
    parameter logic [12:0] baseAddr = 13'h100
) (
    input logic busClk,
    input logic rstN,
    input logic pSel,
    input logic pEnable,
    input logic pWrite,
    input logic [12:0] pAddr,
    input logic [31:0] pWData,
    input logic [3:0] pStrb,
    output logic [31:0] pRData,
    output logic pReady,
    output logic pSlvErr,
    input logic framesync,
    input framerPkg::syncStateT syncState,
    input logic invertData,
    framerCfgIf.cfgSource cfg
);
    import framerPkg::*;

    ctrlWordU ctrlReg;
    logic [windowWidth-1:0] syncWordReg;
    logic [windowWidth-1:0] syncMaskReg;

    logic [3:0] regOffset;
    logic inWindow;
    logic mapped;
    logic accessPhase;
    logic wrEn;

    assign regOffset = pAddr[3:0];
    assign inWindow = (pAddr[12:4] == baseAddr[12:4]);
    assign mapped = inWindow && (regOffset inside {ctrlOffset, syncWordOffset,
                                                   syncMaskOffset, statusOffset});
    assign accessPhase = pSel && pEnable;

    assign pReady = 1'b1;                   // Every transfer completes without wait states.
    assign pSlvErr = accessPhase && (!mapped || (pWrite && regOffset == statusOffset));
    assign wrEn = accessPhase && pWrite && !pSlvErr;

    always_ff @(posedge busClk) begin
        if (!rstN) begin
            ctrlReg.raw <= '0;
            syncWordReg <= '0;
            syncMaskReg <= '0;
        end else if (wrEn) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (pStrb[lane]) begin
                    case (regOffset)
                        ctrlOffset: ctrlReg.raw[8*lane +: 8] <=
                            pWData[8*lane +: 8] & ctrlRwMask[8*lane +: 8];
                        syncWordOffset: syncWordReg[8*lane +: 8] <= pWData[8*lane +: 8];
                        syncMaskOffset: syncMaskReg[8*lane +: 8] <= pWData[8*lane +: 8];
                        default: ;
                    endcase
                end
            end
        end
    end

    always_comb begin
        pRData = '0;
        if (pSel && mapped && !pSlvErr) begin
            case (regOffset)
                ctrlOffset: pRData = ctrlReg.raw;
                syncWordOffset: pRData = syncWordReg;
                syncMaskOffset: pRData = syncMaskReg;
                statusOffset: pRData = {23'd0, invertData, 2'd0, syncState, 3'd0, framesync};
                default: pRData = '0;
            endcase
        end
    end

    assign cfg.bitsPerWord = ctrlReg.fields.bitsPerWord;
    assign cfg.wordsPerFrame = ctrlReg.fields.wordsPerFrame;
    assign cfg.syncThreshold = ctrlReg.fields.syncThreshold;
    assign cfg.syncWord = syncWordReg;
    assign cfg.syncMask = syncMaskReg;

    // An access cycle always follows a setup cycle of the same transfer.
    apbAccessAfterSetup: assert property (
        @(posedge busClk) disable iff (!rstN)
        pEnable |-> pSel && $past(pSel && !pEnable)
    );

endmodule

/* bitShifter.sv */
`timescale 1ns/1ps

module bitShifter (
    input logic busClk,
    input logic rstN,
    input logic serialBit,
    input logic serialValid,
    output logic bitValid,
    output logic [framerPkg::windowWidth-1:0] window
);

    always_ff @(posedge busClk) begin
        if (!rstN) begin
            bitValid <= 1'b0;
        end else begin
            bitValid <= serialValid;
        end
    end

    // The newest bit enters at the LSB, so the oldest bit of the window is the MSB.
    always_ff @(posedge busClk) begin
        if (!rstN) begin
            window <= '0;                   // Search starts from a known window.
        end else if (serialValid) begin
            window <= {window[$bits(window)-2:0], serialBit};
        end
    end

endmodule

/* syncCorrelator.sv */
`timescale 1ns/1ps

module syncCorrelator (
    input logic busClk,
    input logic rstN,
    input logic bitValid,
    input logic [framerPkg::windowWidth-1:0] windowIn,
    framerCfgIf.cfgSink cfg,
    output logic scoreValid,
    output logic signed [framerPkg::scoreWidth-1:0] score,
    output logic [framerPkg::windowWidth-1:0] windowOut
);
    import framerPkg::*;

    logic [5:0] agreeCount;                 // Up to 32 masked bits agree.
    logic [5:0] diffCount;
    logic signed [scoreWidth-1:0] rawScore;

    always_comb begin
        agreeCount = '0;
        diffCount = '0;
        for (int i = 0; i < windowWidth; i++) begin
            if (cfg.syncMask[i]) begin
                if (windowIn[i] == cfg.syncWord[i]) begin
                    agreeCount = agreeCount + 6'd1;
                end else begin
                    diffCount = diffCount + 6'd1;
                end
            end
        end
    end

    assign rawScore = $signed({1'b0, agreeCount}) - $signed({1'b0, diffCount});

    always_ff @(posedge busClk) begin
        if (!rstN) begin
            scoreValid <= 1'b0;
        end else begin
            scoreValid <= bitValid;
        end
    end

    // Window travels with its score so the FSM sees both for the same bit.
    always_ff @(posedge busClk) begin
        if (bitValid) begin
            score <= rawScore;
            windowOut <= windowIn;
        end
    end

    // At most 32 masked bits can agree or differ.
    scoreInRange: assert property (
        @(posedge busClk) disable iff (!rstN)
        scoreValid |-> (score >= -7'sd32) && (score <= 7'sd32)
    );

endmodule

/* frameSyncFsm.sv */
`timescale 1ns/1ps

module frameSyncFsm (
    input logic busClk,
    input logic rstN,
    input logic scoreValid,
    input logic signed [framerPkg::scoreWidth-1:0] score,
    input logic [framerPkg::windowWidth-1:0] window,
    framerCfgIf.cfgSink cfg,
    output logic [framerPkg::windowWidth-1:0] outWord,
    output logic outWordValid,
    output logic outFrameStart,
    output logic framesync,
    output framerPkg::syncStateT syncState,
    output logic invertData
);
    import framerPkg::*;

    syncStateT nextState;
    logic nextInvert;
    logic [4:0] bitCnt;                     // Bit position inside the current word.
    logic [15:0] wordCnt;                   // Word position inside the current frame.
    logic wordEnd;
    logic frameEnd;
    logic normMatch;
    logic invMatch;
    logic syncPass;
    logic [windowWidth-1:0] wordMask;

    assign wordEnd = (bitCnt == cfg.bitsPerWord);
    assign frameEnd = wordEnd && (wordCnt == cfg.wordsPerFrame - 16'd1);
    assign normMatch = (score >= cfg.syncThreshold);
    assign invMatch = (score <= -cfg.syncThreshold);
    assign syncPass = invertData ? invMatch : normMatch;
    assign wordMask = ~({{(windowWidth-1){1'b1}}, 1'b0} << cfg.bitsPerWord);
    assign framesync = (syncState == stLocked) || (syncState == stFlywheel);

    always_comb begin
        nextState = syncState;
        nextInvert = invertData;
        if (scoreValid) begin
            case (syncState)
                stSearch: begin
                    if (normMatch) begin
                        nextState = stCheck;
                        nextInvert = 1'b0;
                    end else if (invMatch) begin
                        nextState = stCheck;
                        nextInvert = 1'b1;
                    end
                end
                stCheck: if (frameEnd) nextState = syncPass ? stLocked : stSearch;
                stLocked: if (frameEnd) nextState = syncPass ? stLocked : stFlywheel;
                stFlywheel: if (frameEnd) nextState = syncPass ? stLocked : stSearch;
                default: nextState = stSearch;
            endcase
        end
    end

    always_ff @(posedge busClk) begin
        if (!rstN) begin
            syncState <= stSearch;
            invertData <= 1'b0;
            bitCnt <= '0;
            wordCnt <= '0;
        end else if (scoreValid) begin
            syncState <= nextState;
            invertData <= nextInvert;
            if (syncState == stSearch) begin
                if (nextState == stCheck) begin // The matching bit becomes the frame end.
                    bitCnt <= '0;
                    wordCnt <= '0;
                end
            end else if (wordEnd) begin
                bitCnt <= '0;
                wordCnt <= frameEnd ? 16'd0 : wordCnt + 16'd1;
            end else begin
                bitCnt <= bitCnt + 5'd1;
            end
        end
    end

    // Output follows the state being entered, so a lost lock emits nothing further.
    always_ff @(posedge busClk) begin
        if (!rstN) begin
            outWordValid <= 1'b0;
            outFrameStart <= 1'b0;
        end else begin
            outWordValid <= scoreValid && (syncState != stSearch) && wordEnd &&
                            (nextState == stLocked || nextState == stFlywheel);
            outFrameStart <= scoreValid && (syncState != stSearch) && frameEnd &&
                             (nextState == stLocked || nextState == stFlywheel);
        end
    end

    always_ff @(posedge busClk) begin
        if (scoreValid && wordEnd) begin
            outWord <= (invertData ? ~window : window) & wordMask;
        end
    end

    frameStartIsWord: assert property (
        @(posedge busClk) disable iff (!rstN)
        outFrameStart |-> outWordValid
    );

    noWordsWithoutLock: assert property (
        @(posedge busClk) disable iff (!rstN)
        outWordValid |-> (syncState == stLocked) || (syncState == stFlywheel)
    );

endmodule

/* framerTop.sv */
`timescale 1ns/1ps

module framerTop #(
    parameter logic [12:0] baseAddr = 13'h100
) (
    input logic busClk,
    input logic rstN,
    input logic pSel,
    input logic pEnable,
    input logic pWrite,
    input logic [12:0] pAddr,
    input logic [31:0] pWData,
    input logic [3:0] pStrb,
    output logic [31:0] pRData,
    output logic pReady,
    output logic pSlvErr,
    input logic serialBit,
    input logic serialValid,
    output logic [framerPkg::windowWidth-1:0] outWord,
    output logic outWordValid,
    output logic outFrameStart
);
    import framerPkg::*;

    logic bitValid;
    logic [windowWidth-1:0] shiftWindow;
    logic scoreValid;
    logic signed [scoreWidth-1:0] score;
    logic [windowWidth-1:0] scoredWindow;
    logic framesync;
    syncStateT syncState;
    logic invertData;

    framerCfgIf cfgBus ();

    framerRegs #(
        .baseAddr(baseAddr)
    ) regs (
        .busClk(busClk), .rstN(rstN),
        .pSel(pSel), .pEnable(pEnable), .pWrite(pWrite), .pAddr(pAddr),
        .pWData(pWData), .pStrb(pStrb),
        .pRData(pRData), .pReady(pReady), .pSlvErr(pSlvErr),
        .framesync(framesync), .syncState(syncState), .invertData(invertData),
        .cfg(cfgBus)
    );

    bitShifter shifter (
        .busClk(busClk), .rstN(rstN),
        .serialBit(serialBit), .serialValid(serialValid),
        .bitValid(bitValid), .window(shiftWindow)
    );

    syncCorrelator correlator (
        .busClk(busClk), .rstN(rstN),
        .bitValid(bitValid), .windowIn(shiftWindow), .cfg(cfgBus),
        .scoreValid(scoreValid), .score(score), .windowOut(scoredWindow)
    );

    frameSyncFsm syncFsm (
        .busClk(busClk), .rstN(rstN),
        .scoreValid(scoreValid), .score(score), .window(scoredWindow), .cfg(cfgBus),
        .outWord(outWord), .outWordValid(outWordValid), .outFrameStart(outFrameStart),
        .framesync(framesync), .syncState(syncState), .invertData(invertData)
    );

endmodule

/* framerTb.sv */
`timescale 1ns/1ps

module framerTb;
    import framerPkg::*;

    localparam string stimFile = "framerStimulus.txt";
    localparam int clkPeriod = 40;
    localparam logic [12:0] baseAddr = 13'h100;

    logic busClk;
    logic rstN;
    logic pSel;
    logic pEnable;
    logic pWrite;
    logic [12:0] pAddr;
    logic [31:0] pWData;
    logic [3:0] pStrb;
    logic [31:0] pRData;
    logic pReady;
    logic pSlvErr;
    logic serialBit;
    logic serialValid;
    logic [31:0] outWord;
    logic outWordValid;
    logic outFrameStart;

    byte cmdKind[$];
    logic [31:0] cmdA[$];                   // Address, or frame count.
    logic [31:0] cmdB[$];                   // Write data, or polarity.
    logic [31:0] cmdC[$];                   // Byte strobes, or corrupted frame index.
    logic [31:0] cmdExp[$];                 // Expected read data, or expected STATUS.
    logic cmdErr[$];
    logic [31:0] cfgCtrl[$];
    logic [31:0] cfgSync[$];
    logic [31:0] cfgMask[$];

    logic [32:0] expWords[$];               // Frame-start flag above the expected word.
    logic [32:0] expWord;
    syncStateT mState;
    logic mInvert;
    logic [4:0] mBit;
    logic [15:0] mWord;
    logic [31:0] mWindow;
    logic [15:0] mWpf;
    logic [4:0] mBpw;
    logic signed [6:0] mThr;
    logic [31:0] mSync;
    logic [31:0] mMask;
    logic [15:0] lfsrState;
    int errors;
    int totalCycles;
    logic armed = 1'b0;

    framerTop #(.baseAddr(baseAddr)) UUT (.*);

    always #(clkPeriod / 2) busClk = ~busClk;

    function automatic logic [15:0] lfsrStep(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [31:0] mergeLanes(input logic [31:0] old, input logic [31:0] data,
                                               input logic [3:0] strb);
        logic [31:0] res;
        res = old;
        for (int lane = 0; lane < 4; lane++) begin
            if (strb[lane]) begin
                res[8*lane +: 8] = data[8*lane +: 8];
            end
        end
        return res;
    endfunction

    task automatic nextCycle();
        @(posedge busClk);
        #2;
    endtask

    task automatic apbTransfer(input logic write, input logic [12:0] addr,
                               input logic [31:0] data, input logic [3:0] strb,
                               output logic [31:0] rdata, output logic err);
        pSel = 1'b1;
        pEnable = 1'b0;
        pWrite = write;
        pAddr = addr;
        pWData = data;
        pStrb = strb;
        nextCycle();
        pEnable = 1'b1;
        @(negedge busClk);                  // Access-cycle outputs have settled by mid-cycle.
        rdata = pRData;
        err = pSlvErr;
        if (pReady !== 1'b1) begin
            errors++;
            $display("pReady was low during an access cycle to %h", addr);
        end
        nextCycle();
        pSel = 1'b0;
        pEnable = 1'b0;
        pWrite = 1'b0;
        pStrb = '0;
    endtask

    task automatic apbWrite(input logic [12:0] addr, input logic [31:0] data,
                            input logic [3:0] strb, output logic err);
        logic [31:0] unused;
        apbTransfer(1'b1, addr, data, strb, unused, err);
    endtask

    task automatic apbRead(input logic [12:0] addr, output logic [31:0] rdata,
                           output logic err);
        apbTransfer(1'b0, addr, 32'd0, 4'd0, rdata, err);
    endtask

    task automatic loadStimulus();
        int fd;
        string line;
        byte kind;
        logic [31:0] a, d, s, r, e;
        int nFrames, pol, corrupt;
        logic [31:0] ctrl, sync, mask;
        ctrl = '0;
        sync = '0;
        mask = '0;
        totalCycles = 0;
        fd = $fopen(stimFile, "r");
        if (fd == 0) begin
            errors++;
            $display("Could not open the stimulus file %s", stimFile);
        end else begin
            while ($fgets(line, fd) != 0) begin
                kind = line.getc(0);
                if (kind == "W" || kind == "R") begin
                    void'($sscanf(line.substr(2, line.len() - 1), "%h %h %h %h %h",
                                  a, d, s, r, e));
                    if (kind == "W" && e == 0) begin
                        case (a[3:0])
                            ctrlOffset: ctrl = mergeLanes(ctrl, d, s[3:0]);
                            syncWordOffset: sync = mergeLanes(sync, d, s[3:0]);
                            syncMaskOffset: mask = mergeLanes(mask, d, s[3:0]);
                            default: ;
                        endcase
                    end
                    totalCycles += 3;
                end else if (kind == "F") begin
                    void'($sscanf(line.substr(2, line.len() - 1), "%d %d %d %h",
                                  nFrames, pol, corrupt, r));
                    a = nFrames;
                    d = pol;
                    s = corrupt;
                    e = '0;
                    totalCycles += nFrames * int'(ctrl[31:16]) * (int'(ctrl[4:0]) + 1) + 8;
                end
                if (kind == "W" || kind == "R" || kind == "F") begin
                    cmdKind.push_back(kind);
                    cmdA.push_back(a);
                    cmdB.push_back(d);
                    cmdC.push_back(s);
                    cmdExp.push_back(r);
                    cmdErr.push_back(e[0]);
                    cfgCtrl.push_back(ctrl);
                    cfgSync.push_back(sync);
                    cfgMask.push_back(mask);
                end
            end
            $fclose(fd);
        end
    endtask

    // Frame rules applied to one received bit.
    task automatic modelBit(input logic b);
        int score;
        logic normMatch;
        logic invMatch;
        logic pass;
        logic wordEnd;
        logic frameEnd;
        logic [31:0] keep;
        mWindow = {mWindow[30:0], b};
        score = 0;
        for (int i = 0; i < 32; i++) begin
            if (mMask[i]) begin
                score += (mWindow[i] == mSync[i]) ? 1 : -1;
            end
        end
        normMatch = (score >= int'(mThr));
        invMatch = (score <= -int'(mThr));
        if (mState == stSearch) begin
            if (normMatch || invMatch) begin
                mState = stCheck;
                mInvert = !normMatch;
                mBit = '0;
                mWord = '0;
            end
        end else begin
            wordEnd = (mBit == mBpw);
            frameEnd = wordEnd && (mWord == mWpf - 16'd1);
            if (frameEnd) begin
                pass = mInvert ? invMatch : normMatch;
                case (mState)
                    stCheck: mState = pass ? stLocked : stSearch;
                    stLocked: mState = pass ? stLocked : stFlywheel;
                    default: mState = pass ? stLocked : stSearch;
                endcase
            end
            if (wordEnd && (mState == stLocked || mState == stFlywheel)) begin
                for (int i = 0; i < 32; i++) begin
                    keep[i] = (i <= int'(mBpw));
                end
                expWords.push_back({frameEnd, (mInvert ? ~mWindow : mWindow) & keep});
            end
            mBit = wordEnd ? 5'd0 : mBit + 5'd1;
            mWord = frameEnd ? 16'd0 : (wordEnd ? mWord + 16'd1 : mWord);
        end
    endtask

    task automatic sendBit(input logic b);
        serialBit = b;
        serialValid = 1'b1;
        modelBit(b);
        nextCycle();
    endtask

    task automatic runFrames(input int idx);
        int corrupt;
        logic pol;
        logic [31:0] syncBits;
        logic [31:0] rdata;
        logic err;
        pol = cmdB[idx][0];
        corrupt = int'(cmdC[idx]);
        mWpf = cfgCtrl[idx][31:16];
        mThr = cfgCtrl[idx][14:8];
        mBpw = cfgCtrl[idx][4:0];
        mSync = cfgSync[idx];
        mMask = cfgMask[idx];
        for (int f = 0; f < int'(cmdA[idx]); f++) begin
            for (int w = 0; w < int'(mWpf) - 1; w++) begin
                for (int b = 0; b <= int'(mBpw); b++) begin
                    lfsrState = lfsrStep(lfsrState);
                    sendBit(lfsrState[0] ^ pol);
                end
            end
            syncBits = (f == corrupt) ? mSync ^ 32'h0000_00FF : mSync;
            for (int b = int'(mBpw); b >= 0; b--) begin
                sendBit(syncBits[b] ^ pol);   // The sync word goes out MSB first.
            end
        end
        serialValid = 1'b0;
        repeat (4) nextCycle();             // Three pipeline stages, then the state settles.
        apbRead(baseAddr + {9'd0, statusOffset}, rdata, err);
        if (rdata !== cmdExp[idx]) begin
            errors++;
            $display("FAILED STATUS after frames (command %0d): expected %h, actual %h",
                     idx, cmdExp[idx], rdata);
        end
        if (err !== 1'b0) begin
            errors++;
            $display("FAILED pSlvErr of STATUS read (command %0d): expected 0, actual %b",
                     idx, err);
        end
        if (expWords.size() != 0) begin
            errors++;
            $display("The DUT left %0d expected words unsent (command %0d)",
                     expWords.size(), idx);
            expWords.delete();
        end
    endtask

    always @(negedge busClk) begin
        if (rstN && outWordValid) begin
            if (expWords.size() == 0) begin
                errors++;
                $display("The DUT sent word %h while no word was expected", outWord);
            end else begin
                expWord = expWords.pop_front();
                if ({outFrameStart, outWord} !== expWord) begin
                    errors++;
                    $display("FAILED word output: expected %h, actual %h",
                             expWord, {outFrameStart, outWord});
                end
            end
        end
    end

    initial begin
        wait (armed);
        #(totalCycles * clkPeriod + 5000);
        $display("Timeout: the command sequence ran past its time budget");
        $display("Testbench failed");
        $finish;
    end

    initial begin
        logic [31:0] rdata;
        logic err;
        busClk = 1'b0;
        rstN = 1'b0;
        pSel = 1'b0;
        pEnable = 1'b0;
        pWrite = 1'b0;
        pAddr = '0;
        pWData = '0;
        pStrb = '0;
        serialBit = 1'b0;
        serialValid = 1'b0;
        errors = 0;
        lfsrState = 16'd64450;
        mState = stSearch;
        mInvert = 1'b0;
        mBit = '0;
        mWord = '0;
        mWindow = '0;
        loadStimulus();
        armed = 1'b1;
        repeat (5) @(posedge busClk);
        #2;
        rstN = 1'b1;
        for (int i = 0; i < cmdKind.size(); i++) begin
            if (cmdKind[i] == "F") begin
                runFrames(i);
            end else begin
                if (cmdKind[i] == "W") begin
                    apbWrite(cmdA[i][12:0], cmdB[i], cmdC[i][3:0], err);
                end else begin
                    apbRead(cmdA[i][12:0], rdata, err);
                    if (rdata !== cmdExp[i]) begin
                        errors++;
                        $display("FAILED read %h: expected %h, actual %h",
                                 cmdA[i][12:0], cmdExp[i], rdata);
                    end
                end
                if (err !== cmdErr[i]) begin
                    errors++;
                    $display("FAILED pSlvErr of command %0d at %h: expected %b, actual %b",
                             i, cmdA[i][12:0], cmdErr[i], err);
                end
            end
        end
        nextCycle();
        $display("Commands run: %0d, errors: %0d", cmdKind.size(), errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

/* list.f */
framerPkg.sv
framerCfgIf.sv
framerRegs.sv
bitShifter.sv
syncCorrelator.sv
frameSyncFsm.sv
framerTop.sv
framerTb.sv

/* Makefile */
VERILATOR = verilator
TOP = framerTb
FILELIST = list.f
VFLAGS = --binary --timing --assert -j 0
OBJDIR = obj_dir
LOG = sim.log
FAIL_MSG = Testbench failed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: compile
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJDIR) $(LOG)

/* framerStimulus.txt */
# W/R lines: address, write data, byte strobes, expected read data, expected pSlvErr (hex).
# F lines: frame count, polarity, corrupted frame index (-1 for none), expected STATUS (hex).
W 100 ffffffff 1 0 0
R 100 0 0 0000001f 0
W 100 ffffffff 2 0 0
R 100 0 0 00007f1f 0
W 100 abcd0000 c 0 0
R 100 0 0 abcd7f1f 0
W 104 11223344 5 0 0
W 104 aabbccdd a 0 0
R 104 0 0 aa22cc44 0
W 108 ffffffff 8 0 0
R 108 0 0 ff000000 0
W 10c ffffffff f 0 1
R 10c 0 0 00000000 0
R 102 0 0 00000000 1
W 102 12345678 f 0 1
W 110 12345678 f 0 1
R 110 0 0 00000000 1
R 100 0 0 abcd7f1f 0
R 104 0 0 aa22cc44 0
R 108 0 0 ff000000 0
W 100 0004201f f 0 0
W 104 1acffc1d f 0 0
W 108 ffffffff f 0 0
F 4 0 -1 00000021
F 1 0 0 00000031
F 1 0 -1 00000021
F 1 0 0 00000031
F 1 0 0 00000000
F 1 0 -1 00000010
F 4 1 -1 00000121
